/* tb/pack_trace.txt */
# command then arguments, lane, mask, data and full mask in hex, counts in decimal
# mode m, write lane mask b0-b7, expect lane word, expect_full mask, credit n, hold h, clear, wait n
mode 0
expect 2 11
expect 2 33
expect 2 66
expect 2 88
write 2 a5 11 22 33 44 55 66 77 88
wait 20
mode 1
expect 1 42
expect 1 86
expect 1 ca
expect 1 21
expect 1 43
expect 1 05
write 1 3f 12 34 56 78 9a bc de f0
write 1 1f a1 b2 c3 d4 e5 ee ee ee
wait 20
mode 2
expect 3 bc
expect 3 39
write 3 7f e4 1b 27 d2 01 02 03 ff
wait 20
mode 0
expect 0 a0
expect 1 b0
expect 2 c0
expect 3 d0
expect 0 a1
expect 1 b1
expect 2 c1
expect 3 d1
write 0 03 a0 a1 00 00 00 00 00 00
write 1 03 b0 b1 00 00 00 00 00 00
write 2 03 c0 c1 00 00 00 00 00 00
write 3 03 d0 d1 00 00 00 00 00 00
wait 30
hold 1
expect 0 50
expect 0 51
expect 0 52
expect 0 53
write 0 ff 50 51 52 53 54 55 56 57
write 0 ff 58 59 5a 5b 5c 5d 5e 5f
write 0 ff 60 61 62 63 64 65 66 67
wait 6
write 0 ff 68 69 6a 6b 6c 6d 6e 6f
wait 4
expect_full 1
expect 0 54
expect 0 55
credit 2
wait 8
clear
expect_full 0
hold 0
wait 10
expect 1 9a
expect 1 9b
write 1 03 9a 9b 00 00 00 00 00 00
wait 20

/* sources.f */
source/pack_pkg.sv
source/miso_fifo.sv
source/bus_arbiter.sv
source/pack_top.sv
tb/tb_pack_top.sv

/* Bender.yml */
package:
  name: pack_top

sources:
  - source/pack_pkg.sv
  - source/miso_fifo.sv
  - source/bus_arbiter.sv
  - source/pack_top.sv
  - target: test
    files:
      - tb/tb_pack_top.sv

/* tb/tb_pack_top.sv */
// testbench that replays a command trace into the packing output stage and checks the bus words
`timescale 1ns/1ns

module tb_pack_top;
    import pack_pkg::*;

    localparam int NUM_LANES   = DEF_NUM_LANES;
    localparam int DATA_LENGTH = DEF_DATA_LENGTH;
    localparam int DATA_WIDTH  = DEF_DATA_WIDTH;
    localparam TRACE = "tb/pack_trace.txt";

    logic                                                  i_clk = 1'b0;
    logic                                                  i_nrst;
    logic                                                  i_clear;
    p_mode_e                                               i_p_mode;
    logic [NUM_LANES-1:0][DATA_LENGTH-1:0][DATA_WIDTH-1:0] i_lane_data;
    logic [NUM_LANES-1:0][DATA_LENGTH-1:0]                 i_lane_valid;
    logic                                                  i_credit_return = 1'b0;
    logic [NUM_LANES-1:0]                                  o_full;
    out_word_t                                             o_out;

    out_word_t exp_q[$];
    int        ret_q[$];
    out_word_t head_word;
    int        cycle_cnt = 0;
    int        limit = 0;
    int        manual = 0;
    logic      hold = 1'b0;
    int        fd;

    pack_top i_pack_top (
        .i_clk           (i_clk),
        .i_nrst          (i_nrst),
        .i_clear         (i_clear),
        .i_p_mode        (i_p_mode),
        .i_lane_data     (i_lane_data),
        .i_lane_valid    (i_lane_valid),
        .i_credit_return (i_credit_return),
        .o_full          (o_full),
        .o_out           (o_out)
    );

    always #10 i_clk = ~i_clk;

    ////////////////////
    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(posedge i_clk);
        #2;
    endtask

    task automatic check_word(input out_word_t got, input out_word_t want);
        if (got.lane !== want.lane) begin
            $display("** Error: o_out.lane = 0x%0h, expected 0x%0h", got.lane, want.lane);
            abort_run();
        end
        if (got.data !== want.data) begin
            $display("** Error: o_out.data = 0x%0h, expected 0x%0h", got.data, want.data);
            abort_run();
        end
    endtask

    task automatic check_full(input logic [NUM_LANES-1:0] got,
                              input logic [NUM_LANES-1:0] want);
        if (got !== want) begin
            $display("** Error: o_full = 0x%0h, expected 0x%0h", got, want);
            abort_run();
        end
    endtask

    // drives one write cycle with bytes from the trace line.
    task automatic drive_write(input logic [31:0] lane, input logic [31:0] mask);
        logic [31:0] byte_val;
        int          rc;
        if (o_full[lane] !== 1'b0) begin
            $display("write offered to lane %0d while it reports full", lane);
            abort_run();
        end
        for (int k = 0; k < DATA_LENGTH; k++) begin
            rc = $fscanf(fd, "%h", byte_val);
            i_lane_data[lane][k] = byte_val[DATA_WIDTH-1:0];
        end
        i_lane_valid[lane] = mask[DATA_LENGTH-1:0];
        next_cycle();
        i_lane_valid = '0;
    endtask

    ////////////////////
    // cycle count and watchdog.
    always @(posedge i_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (limit != 0 && cycle_cnt > limit) begin
            $display("timeout, the run did not finish within %0d cycles", limit);
            abort_run();
        end
    end

    // bus monitor samples mid-cycle where o_out is settled.
    always @(negedge i_clk) begin
        if (i_nrst === 1'b1 && o_out.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("word from lane %0d arrived with nothing expected", o_out.lane);
                abort_run();
            end else begin
                head_word = exp_q.pop_front();
                check_word(o_out, head_word);
                ret_q.push_back(cycle_cnt + 3);
            end
        end
    end

    // consumer hands a credit back a few cycles after each word.
    always @(posedge i_clk) begin
        #2;
        i_credit_return = 1'b0;
        if (ret_q.size() != 0 && ret_q[0] <= cycle_cnt && (!hold || manual > 0)) begin
            void'(ret_q.pop_front());
            i_credit_return = 1'b1;
            if (hold) begin
                manual = manual - 1;
            end
        end
    end

    ////////////////////
    initial begin : run_trace
        logic [8*16-1:0]  cmd;
        logic [8*128-1:0] line;
        logic [31:0]      arg0;
        logic [31:0]      arg1;
        out_word_t        exp_in;
        int               n_lines;
        int               code;
        i_nrst       = 1'b0;
        i_clear      = 1'b0;
        i_p_mode     = mode_8b;
        i_lane_data  = '0;
        i_lane_valid = '0;

        // size the watchdog from the trace length.
        fd = $fopen(TRACE, "r");
        if (fd == 0) begin
            $display("cannot open the trace file %0s", TRACE);
            abort_run();
        end
        n_lines = 0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code != 0) begin
                n_lines = n_lines + 1;
            end
        end
        $fclose(fd);
        limit = n_lines * 20 + 200;
        fd = $fopen(TRACE, "r");

        repeat (8) @(posedge i_clk);
        #2;
        i_nrst = 1'b1;

        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == "#") begin
                code = $fgets(line, fd);
            end else if (cmd == "mode") begin
                code = $fscanf(fd, "%h", arg0);
                i_p_mode = p_mode_e'(arg0[1:0]);
            end else if (cmd == "write") begin
                code = $fscanf(fd, "%h %h", arg0, arg1);
                drive_write(arg0, arg1);
            end else if (cmd == "expect") begin
                code = $fscanf(fd, "%h %h", arg0, arg1);
                exp_in.valid = 1'b1;
                exp_in.lane  = arg0[LANE_W-1:0];
                exp_in.data  = arg1[DATA_WIDTH-1:0];
                exp_q.push_back(exp_in);
            end else if (cmd == "expect_full") begin
                code = $fscanf(fd, "%h", arg0);
                check_full(o_full, arg0[NUM_LANES-1:0]);
            end else if (cmd == "credit") begin
                code = $fscanf(fd, "%d", arg0);
                manual = manual + int'(arg0);
            end else if (cmd == "hold") begin
                code = $fscanf(fd, "%h", arg0);
                hold = arg0[0];
            end else if (cmd == "clear") begin
                i_clear = 1'b1;
                next_cycle();
                i_clear = 1'b0;
            end else if (cmd == "wait") begin
                code = $fscanf(fd, "%d", arg0);
                repeat (arg0) next_cycle();
            end else begin
                $display("unknown command in the trace file");
                abort_run();
            end
        end
        $fclose(fd);

        if (exp_q.size() != 0) begin
            $display("%0d expected words never arrived", exp_q.size());
            abort_run();
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

/* source/pack_top.sv */
// output stage joining the lane FIFOs onto one credit-controlled bus
`timescale 1ns/1ns

module pack_top #(
    parameter int DEPTH       = pack_pkg::DEF_DEPTH,
    parameter int DATA_WIDTH  = pack_pkg::DEF_DATA_WIDTH,
    parameter int DATA_LENGTH = pack_pkg::DEF_DATA_LENGTH,
    parameter int NUM_LANES   = pack_pkg::DEF_NUM_LANES,
    parameter int CREDITS     = pack_pkg::DEF_CREDITS
) (
    input  logic                                                  i_clk,
    input  logic                                                  i_nrst,
    input  logic                                                  i_clear,
    input  pack_pkg::p_mode_e                                     i_p_mode,
    input  logic [NUM_LANES-1:0][DATA_LENGTH-1:0][DATA_WIDTH-1:0] i_lane_data,
    input  logic [NUM_LANES-1:0][DATA_LENGTH-1:0]                 i_lane_valid,
    input  logic                                                  i_credit_return,
    output logic [NUM_LANES-1:0]                                  o_full,
    output pack_pkg::out_word_t                                   o_out
);
    import pack_pkg::*;

    logic [NUM_LANES-1:0]                 fifo_empty;
    logic [NUM_LANES-1:0]                 arb_empty;
    logic [NUM_LANES-1:0]                 fifo_pop;
    logic [NUM_LANES-1:0]                 pop_valid;
    logic [NUM_LANES-1:0][DATA_WIDTH-1:0] pop_data;
    logic [LANE_W-1:0]                    grant_lane;
    logic [LANE_W-1:0]                    grant_lane_q;
    logic [DATA_WIDTH-1:0]                sel_data;

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        miso_fifo #(
            .DEPTH       (DEPTH),
            .DATA_WIDTH  (DATA_WIDTH),
            .DATA_LENGTH (DATA_LENGTH)
        ) i_miso_fifo (
            .i_clk       (i_clk),
            .i_nrst      (i_nrst),
            .i_clear     (i_clear),
            .i_write_en  (|i_lane_valid[g]),
            .i_p_mode    (i_p_mode),
            .i_data      (i_lane_data[g]),
            .i_valid     (i_lane_valid[g]),
            .i_pop_en    (fifo_pop[g]),
            .o_data      (pop_data[g]),
            .o_pop_valid (pop_valid[g]),
            .o_empty     (fifo_empty[g]),
            .o_full      (o_full[g])
        );
    end

    // no grant during clear, the popped word would be lost with its credit.
    assign arb_empty = fifo_empty | {NUM_LANES{i_clear}};

    bus_arbiter #(
        .NUM_LANES (NUM_LANES),
        .CREDITS   (CREDITS)
    ) i_bus_arbiter (
        .i_clk           (i_clk),
        .i_nrst          (i_nrst),
        .i_empty         (arb_empty),
        .i_credit_return (i_credit_return),
        .o_pop           (fifo_pop),
        .o_grant_lane    (grant_lane)
    );

    // lane index follows the registered FIFO data by one cycle.
    always_ff @(posedge i_clk) begin
        grant_lane_q <= grant_lane;
    end

    always_comb begin
        sel_data = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (pop_valid[i]) begin
                sel_data = pop_data[i];
            end
        end
    end

    always_comb begin
        o_out.valid = |pop_valid;
        o_out.lane  = (|pop_valid) ? grant_lane_q : '0;
        o_out.data  = sel_data;
    end

endmodule

/* source/bus_arbiter.sv */
// round-robin grant of the shared output bus, held back by downstream credits
`timescale 1ns/1ns

module bus_arbiter #(
    parameter int NUM_LANES = 4,
    parameter int CREDITS   = 4
) (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  logic [NUM_LANES-1:0]        i_empty,
    input  logic                        i_credit_return,
    output logic [NUM_LANES-1:0]        o_pop,
    output logic [pack_pkg::LANE_W-1:0] o_grant_lane
);
    import pack_pkg::*;

    localparam int CRED_W = $clog2(CREDITS + 1);

    logic [LANE_W-1:0] rr_ptr;
    logic [CRED_W-1:0] credit_cnt;
    logic              grant;

    ////////////////////
    // first nonempty lane at or after the pointer.
    always_comb begin
        int   idx;
        logic found;
        o_pop        = '0;
        o_grant_lane = '0;
        found        = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            idx = int'(rr_ptr) + i;
            if (idx >= NUM_LANES) begin
                idx = idx - NUM_LANES;
            end
            if (!found && credit_cnt != '0 && !i_empty[idx]) begin
                o_pop[idx]   = 1'b1;
                o_grant_lane = LANE_W'(idx);
                found        = 1'b1;
            end
        end
    end

    assign grant = |o_pop;

    ////////////////////
    // pointer and credit state.
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rr_ptr     <= '0;
            credit_cnt <= CRED_W'(CREDITS);
        end else begin
            if (grant) begin
                rr_ptr <= (o_grant_lane == LANE_W'(NUM_LANES - 1)) ? '0 :
                          o_grant_lane + 1'b1;
            end
            // return and grant together cancel out.
            case ({i_credit_return, grant})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    ////////////////////
    a_pop_onehot: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $onehot0(o_pop));

    a_no_grant_broke: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (credit_cnt == '0) |-> !grant);

    // the consumer must not hand back more than it received.
    a_credit_bound: assert property (@(posedge i_clk) disable iff (!i_nrst)
        credit_cnt <= CRED_W'(CREDITS));

endmodule

/* source/miso_fifo.sv */
// per-lane FIFO taking several entries per write and packing narrow entries on pop
`timescale 1ns/1ns

module miso_fifo #(
    parameter int DEPTH       = 32,
    parameter int DATA_WIDTH  = 8,
    parameter int DATA_LENGTH = 8
) (
    input  logic                                   i_clk,
    input  logic                                   i_nrst,
    input  logic                                   i_clear,
    input  logic                                   i_write_en,
    input  pack_pkg::p_mode_e                      i_p_mode,
    input  logic [DATA_LENGTH-1:0][DATA_WIDTH-1:0] i_data,
    input  logic [DATA_LENGTH-1:0]                 i_valid,
    input  logic                                   i_pop_en,
    output logic [DATA_WIDTH-1:0]                  o_data,
    output logic                                   o_pop_valid,
    output logic                                   o_empty,
    output logic                                   o_full
);
    import pack_pkg::*;

    // depth is a power of two, so pointers wrap on their own.
    localparam int ADDR_W = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int HALF   = DATA_WIDTH / 2;
    localparam int QUART  = DATA_WIDTH / 4;

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [ADDR_W-1:0]     wr_ptr;
    logic [ADDR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  write_en;
    logic [ADDR_W-1:0]     wr_addr [DATA_LENGTH];
    logic [CNT_W-1:0]      wr_num;
    logic                  pop_fire;
    logic [ADDR_W-1:0]     rd_addr [4];
    logic [CNT_W-1:0]      want_num;
    logic [CNT_W-1:0]      take_num;
    logic [DATA_WIDTH-1:0] pack_word;

    assign write_en = i_write_en & ~o_full;
    assign pop_fire = i_pop_en & ~o_empty;

    ////////////////////
    // write side.
    // valid entries land back to back, gaps in the mask are squeezed out.
    always_comb begin
        wr_num = '0;
        for (int i = 0; i < DATA_LENGTH; i++) begin
            wr_addr[i] = wr_ptr + ADDR_W'(wr_num);
            wr_num     = wr_num + CNT_W'(i_valid[i]);
        end
    end

    always_ff @(posedge i_clk) begin
        if (write_en) begin
            for (int i = 0; i < DATA_LENGTH; i++) begin
                if (i_valid[i]) begin
                    mem[wr_addr[i]] <= i_data[i];
                end
            end
        end
    end

    ////////////////////
    // pop side.
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rd_addr[k] = rd_ptr + ADDR_W'(k);
        end
    end

    always_comb begin
        case (i_p_mode)
            mode_4b: want_num = CNT_W'(2);
            mode_2b: want_num = CNT_W'(4);
            default: want_num = CNT_W'(1);
        endcase
        take_num = (count < want_num) ? count : want_num;
    end

    // field k holds entry k, oldest entry in the low field.
    // fields with no entry behind them stay zero.
    always_comb begin
        pack_word = '0;
        case (i_p_mode)
            mode_4b: begin
                for (int k = 0; k < 2; k++) begin
                    if (CNT_W'(k) < take_num) begin
                        pack_word[k*HALF +: HALF] = mem[rd_addr[k]][HALF-1:0];
                    end
                end
            end
            mode_2b: begin
                for (int k = 0; k < 4; k++) begin
                    if (CNT_W'(k) < take_num) begin
                        pack_word[k*QUART +: QUART] = mem[rd_addr[k]][QUART-1:0];
                    end
                end
            end
            default: pack_word = mem[rd_addr[0]];
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (pop_fire) begin
            o_data <= pack_word;
        end
    end

    ////////////////////
    // pointers and occupancy.
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            o_pop_valid <= 1'b0;
        end else if (i_clear) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            o_pop_valid <= 1'b0;
        end else begin
            if (write_en) begin
                wr_ptr <= wr_ptr + ADDR_W'(wr_num);
            end
            if (pop_fire) begin
                rd_ptr <= rd_ptr + ADDR_W'(take_num);
            end
            count       <= count + (write_en ? wr_num : '0) - (pop_fire ? take_num : '0);
            o_pop_valid <= pop_fire;
        end
    end

    assign o_empty = (count == '0);
    // full once a whole-width write might not fit.
    assign o_full  = (count > CNT_W'(DEPTH - DATA_LENGTH));

    ////////////////////
    // the arbiter must never pop an empty lane.
    a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_pop_en |-> !o_empty);

    a_count_bound: assert property (@(posedge i_clk) disable iff (!i_nrst)
        count <= CNT_W'(DEPTH));

endmodule

/* source/pack_pkg.sv */
// shared mode, bus word and default sizes for the precision-packing output stage
package pack_pkg;

    ////////////////////
    // default sizes passed down from the top level.
    localparam int DEF_DEPTH       = 32;
    localparam int DEF_DATA_WIDTH  = 8;
    localparam int DEF_DATA_LENGTH = 8;
    localparam int DEF_NUM_LANES   = 4;
    localparam int DEF_CREDITS     = 4;

    // lane index width, fixed so the bus word stays a fixed type.
    // at most four lanes.
    localparam int LANE_W = 2;

    ////////////////////
    // precision modes.
    typedef enum logic [1:0] {
        mode_8b = 2'b00,
        mode_4b = 2'b01,
        mode_2b = 2'b10
    } p_mode_e;

    ////////////////////
    // output bus word.
    typedef struct packed {
        logic                      valid;
        logic [LANE_W-1:0]         lane;
        logic [DEF_DATA_WIDTH-1:0] data;
    } out_word_t;

endpackage
